/* Makefile */
# Verilator build for the divide unit testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/cla_64.sv */
module cla_64 (
  input  div_pkg::xlen_t a_64,
  input  div_pkg::xlen_t b_64,
  input  logic           cin_64,
  output div_pkg::xlen_t s_64,
  output logic           gx_64,
  output logic           px_64
);
  import div_pkg::*;

  localparam int NGRP = 16;
  localparam int NBLK = 4;

  xlen_t            g;
  xlen_t            p;
  xlen_t            c;
  logic [NGRP-1:0]  grp_g;
  logic [NGRP-1:0]  grp_p;
  logic [NGRP-1:0]  grp_c;
  logic [NBLK-1:0]  blk_g;
  logic [NBLK-1:0]  blk_p;
  logic [NBLK-1:0]  blk_c;

  // 4-wide lookahead cell returning {group g, group p, carries into each position}
  function automatic logic [5:0] lookahead4(
    input logic [3:0] gi,
    input logic [3:0] pi,
    input logic       ci
  );
    logic [3:0] cy;
    logic       gg;
    cy[0] = ci;
    cy[1] = gi[0] | (pi[0] & ci);
    cy[2] = gi[1] | (pi[1] & gi[0]) | (pi[1] & pi[0] & ci);
    cy[3] = gi[2] | (pi[2] & gi[1]) | (pi[2] & pi[1] & gi[0]) | (pi[2] & pi[1] & pi[0] & ci);
    gg = gi[3] | (pi[3] & gi[2]) | (pi[3] & pi[2] & gi[1]) | (pi[3] & pi[2] & pi[1] & gi[0]);
    return {gg, &pi, cy};
  endfunction

  always_comb begin
    logic [5:0] la;
    g = a_64 & b_64;
    p = a_64 ^ b_64;
    // group terms do not depend on any carry
    for (int i = 0; i < NGRP; i++) begin
      la = lookahead4(g[4*i +: 4], p[4*i +: 4], 1'b0);
      grp_g[i] = la[5];
      grp_p[i] = la[4];
    end
    for (int j = 0; j < NBLK; j++) begin
      la = lookahead4(grp_g[4*j +: 4], grp_p[4*j +: 4], 1'b0);
      blk_g[j] = la[5];
      blk_p[j] = la[4];
    end
    // top cell gives the carries into each 16-bit block
    la = lookahead4(blk_g, blk_p, cin_64);
    gx_64 = la[5];
    px_64 = la[4];
    blk_c = la[3:0];
    // push carries back down to groups, then to bits
    for (int j = 0; j < NBLK; j++) begin
      la = lookahead4(grp_g[4*j +: 4], grp_p[4*j +: 4], blk_c[j]);
      grp_c[4*j +: 4] = la[3:0];
    end
    for (int i = 0; i < NGRP; i++) begin
      la = lookahead4(g[4*i +: 4], p[4*i +: 4], grp_c[i]);
      c[4*i +: 4] = la[3:0];
    end
  end

  assign s_64 = p ^ c;

endmodule

/* hdl/div_cfg.svh */
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// operand and result width
`define DIV_XLEN 64

// one quotient bit per step
`define DIV_STEPS 64

// counts DIV_STEPS-1 down to zero
`define DIV_CNT_W 6

`endif

/* hdl/div_fixup.sv */
module div_fixup (
  div_raw_if.fixup       raw,
  input  logic           div_valid,
  output logic           out_valid,
  output div_pkg::xlen_t result
);
  import div_pkg::*;

  logic  rem_neg;
  xlen_t rem_restored;
  xlen_t rem_signed;
  xlen_t quo_signed;

  // last quotient bit is clear exactly when the final remainder went negative
  assign rem_neg      = ~raw.quo_raw[0];
  assign rem_restored = rem_neg ? raw.rem_raw + raw.divisor_pos : raw.rem_raw;

  // truncating division takes the quotient sign from both operands
  assign quo_signed = (raw.dividend_sign ^ raw.divisor_sign) ?
                      ~raw.quo_raw + xlen_t'(1) : raw.quo_raw;
  // remainder follows the dividend
  assign rem_signed = raw.dividend_sign ? ~rem_restored + xlen_t'(1) : rem_restored;

  assign result = (raw.op.want_rem == DIV_SEL_REM) ? rem_signed : quo_signed;

  // a request in flight hides the old answer
  assign out_valid = ~raw.busy & ~div_valid;

  a_result_known: assert property (@(posedge raw.clk) disable iff (!raw.rst_n)
    out_valid |-> !$isunknown(result));

endmodule

/* hdl/div_if.sv */
// conditioned operands from prep to iter
interface div_opnd_if;
  import div_pkg::*;

  // accepted request, already masked by flush
  logic    start;
  div_op_t op;
  xlen_t   dividend_mag;
  xlen_t   divisor_pos;
  // two's complement of divisor_pos
  xlen_t   divisor_neg;
  // zero for unsigned operations
  logic    dividend_sign;
  logic    divisor_sign;

  modport prep (
    output start,
    output op,
    output dividend_mag,
    output divisor_pos,
    output divisor_neg,
    output dividend_sign,
    output divisor_sign
  );

  modport iter (
    input start,
    input op,
    input dividend_mag,
    input divisor_pos,
    input divisor_neg,
    input dividend_sign,
    input divisor_sign
  );
endinterface

// raw iteration state from iter to fixup
interface div_raw_if (
  input logic clk,
  input logic rst_n
);
  import div_pkg::*;

  logic    busy;
  // upper and lower halves of the working register
  xlen_t   rem_raw;
  xlen_t   quo_raw;
  div_op_t op;
  logic    dividend_sign;
  logic    divisor_sign;
  xlen_t   divisor_pos;

  modport iter (
    output busy,
    output rem_raw,
    output quo_raw,
    output op,
    output dividend_sign,
    output divisor_sign,
    output divisor_pos
  );

  modport fixup (
    input clk,
    input rst_n,
    input busy,
    input rem_raw,
    input quo_raw,
    input op,
    input dividend_sign,
    input divisor_sign,
    input divisor_pos
  );
endinterface

/* hdl/div_iter.sv */
`include "div_cfg.svh"

module div_iter (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush,
  div_opnd_if.iter opnd,
  div_raw_if.iter  raw
);
  import div_pkg::*;

  localparam int W = `DIV_XLEN;

  // partial remainder on top with dividend bits shifting out below as quotient bits shift in
  logic [2*W-1:0]        work;
  // bit 64 of the partial remainder for unsigned divisors above 2^63
  logic                  rem_top;
  logic [`DIV_CNT_W-1:0] step_cnt;
  logic                  busy;
  div_op_t               op_q;
  logic                  dividend_sign_q;
  logic                  divisor_sign_q;
  xlen_t                 divisor_pos_q;
  xlen_t                 divisor_neg_q;

  xlen_t shifted;
  xlen_t addend;
  xlen_t sum;
  logic  sub;
  logic  sum_gx;
  logic  sum_top;
  logic  q_bit;

  // subtract while the remainder is non-negative, add back otherwise
  assign sub     = ~rem_top;
  // low bits of 2R plus the next dividend bit
  assign shifted = work[2*W-2 -: W];
  assign addend  = sub ? divisor_neg_q : divisor_pos_q;

  cla_64 i_cla (
    .a_64   (shifted),
    .b_64   (addend),
    .cin_64 (1'b0),
    .s_64   (sum),
    .gx_64  (sum_gx),
    .px_64  ()
  );

  // bit 64 of the sum adds R[63], the addend sign and the carry out
  assign sum_top = work[2*W-1] ^ sub ^ sum_gx;
  assign q_bit   = ~sum_top;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      work            <= '0;
      rem_top         <= 1'b0;
      op_q            <= '0;
      dividend_sign_q <= 1'b0;
      divisor_sign_q  <= 1'b0;
      divisor_pos_q   <= '0;
      divisor_neg_q   <= '0;
    end else if (opnd.start) begin
      work            <= {{W{1'b0}}, opnd.dividend_mag};
      rem_top         <= 1'b0;
      op_q            <= opnd.op;
      dividend_sign_q <= opnd.dividend_sign;
      divisor_sign_q  <= opnd.divisor_sign;
      divisor_pos_q   <= opnd.divisor_pos;
      divisor_neg_q   <= opnd.divisor_neg;
    end else if (busy && !flush) begin
      work    <= {sum, work[W-2:0], q_bit};
      rem_top <= sum_top;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      step_cnt <= '0;
    end else if (flush) begin
      busy     <= 1'b0;
      step_cnt <= '0;
    end else if (opnd.start) begin
      busy     <= 1'b1;
      step_cnt <= `DIV_CNT_W'(`DIV_STEPS - 1);
    end else if (busy) begin
      // last step happens on the edge that sees zero
      if (step_cnt == '0) begin
        busy <= 1'b0;
      end else begin
        step_cnt <= step_cnt - 1'b1;
      end
    end
  end

  assign raw.busy          = busy;
  assign raw.rem_raw       = work[2*W-1:W];
  assign raw.quo_raw       = work[W-1:0];
  assign raw.op            = op_q;
  assign raw.dividend_sign = dividend_sign_q;
  assign raw.divisor_sign  = divisor_sign_q;
  assign raw.divisor_pos   = divisor_pos_q;

  // idle unit has no steps left
  a_idle_cnt_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> (step_cnt == '0));

  // only flush cuts a division short
  a_busy_until_done: assert property (@(posedge clk) disable iff (!rst_n)
    (busy && (step_cnt != '0) && !flush) |=> busy);

endmodule

/* hdl/div_pkg.sv */
`include "div_cfg.svh"

package div_pkg;

  // operands and results
  typedef logic [`DIV_XLEN-1:0] xlen_t;

  // operand interpretation from div_type bit 0
  typedef enum logic {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_sign_e;

  // result select from div_type bit 1
  typedef enum logic {
    DIV_SEL_QUO = 1'b0,
    DIV_SEL_REM = 1'b1
  } div_sel_e;

  // packed so the bit layout follows div_type
  typedef struct packed {
    div_sel_e  want_rem;
    div_sign_e is_signed;
  } div_op_t;

endpackage

/* hdl/div_prep.sv */
`include "div_cfg.svh"

module div_prep (
  input  div_pkg::xlen_t   dividend,
  input  div_pkg::xlen_t   divisor,
  input  logic             div_valid,
  input  logic             flush,
  input  div_pkg::div_op_t div_type,
  div_opnd_if.prep         opnd
);
  import div_pkg::*;

  xlen_t dividend_neg;
  xlen_t divisor_neg;
  logic  dividend_s;
  logic  divisor_s;

  assign dividend_neg = ~dividend + xlen_t'(1);
  assign divisor_neg  = ~divisor + xlen_t'(1);

  // sign bits only count for signed operations
  assign dividend_s = (div_type.is_signed == DIV_SIGNED) & dividend[`DIV_XLEN-1];
  assign divisor_s  = (div_type.is_signed == DIV_SIGNED) & divisor[`DIV_XLEN-1];

  // flush wins over a request in the same cycle
  assign opnd.start = div_valid & ~flush;
  assign opnd.op    = div_type;

  assign opnd.dividend_mag = dividend_s ? dividend_neg : dividend;
  assign opnd.divisor_pos  = divisor_s ? divisor_neg : divisor;
  // a negative divisor already is minus its magnitude
  assign opnd.divisor_neg  = divisor_s ? divisor : divisor_neg;

  assign opnd.dividend_sign = dividend_s;
  assign opnd.divisor_sign  = divisor_s;

endmodule

/* hdl/div_top.sv */
module div_top (
  input  logic           clk,
  input  logic           rst_n,
  input  div_pkg::xlen_t dividend,
  input  div_pkg::xlen_t divisor,
  input  logic           div_valid,
  input  logic [1:0]     div_type,
  input  logic           flush,
  output logic           out_valid,
  output div_pkg::xlen_t result
);
  import div_pkg::*;

  div_op_t op_req;

  // bit 0 signed, bit 1 remainder
  assign op_req = div_op_t'(div_type);

  div_opnd_if opnd ();

  div_raw_if raw (
    .clk   (clk),
    .rst_n (rst_n)
  );

  div_prep i_prep (
    .dividend  (dividend),
    .divisor   (divisor),
    .div_valid (div_valid),
    .flush     (flush),
    .div_type  (op_req),
    .opnd      (opnd.prep)
  );

  div_iter i_iter (
    .clk   (clk),
    .rst_n (rst_n),
    .flush (flush),
    .opnd  (opnd.iter),
    .raw   (raw.iter)
  );

  div_fixup i_fixup (
    .raw       (raw.fixup),
    .div_valid (div_valid),
    .out_valid (out_valid),
    .result    (result)
  );

endmodule

/* project.f */
+incdir+hdl
hdl/div_pkg.sv
hdl/div_if.sv
hdl/cla_64.sv
hdl/div_prep.sv
hdl/div_iter.sv
hdl/div_fixup.sv
hdl/div_top.sv
test/div_tb.sv

/* test/div_tb.sv */
`include "div_cfg.svh"

module div_tb;
  import div_pkg::*;

  // 40 + 40 + 32 signed + 2 flush + 2 restart
  localparam int N_REQ         = 116;
  localparam int RESET_CYCLES  = 10;
  localparam int CLK_PERIOD    = 4;
  localparam int WATCHDOG_TIME = (N_REQ * 70 + RESET_CYCLES) * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  xlen_t      dividend;
  xlen_t      divisor;
  logic       div_valid;
  logic [1:0] div_type;
  logic       flush;
  logic       out_valid;
  xlen_t      result;

  // reference side
  xlen_t       req_exp;
  xlen_t       exp_result;
  logic        result_known;
  logic [6:0]  steps_left;
  logic        exp_out_valid;
  logic [63:0] rng;

  div_top i_div_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .dividend  (dividend),
    .divisor   (divisor),
    .div_valid (div_valid),
    .div_type  (div_type),
    .flush     (flush),
    .out_valid (out_valid),
    .result    (result)
  );

  always #2 clk = ~clk;

  function automatic logic [63:0] xorshift64(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // truncating division with the remainder taking the dividend's sign
  function automatic xlen_t ref_result(input xlen_t a, input xlen_t b, input logic [1:0] t);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = a;
    sb = b;
    if (t[0]) begin
      return t[1] ? sa % sb : sa / sb;
    end
    return t[1] ? a % b : a / b;
  endfunction

  // cycle-level model of busy time and the answer being held
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      steps_left   <= 7'd0;
      exp_result   <= '0;
      result_known <= 1'b1;
    end else if (div_valid && !flush) begin
      steps_left   <= 7'd64;
      exp_result   <= req_exp;
      result_known <= 1'b1;
    end else if (flush) begin
      steps_left   <= 7'd0;
      result_known <= 1'b0;
    end else if (steps_left != 7'd0) begin
      steps_left <= steps_left - 7'd1;
    end
  end

  assign exp_out_valid = (steps_left == 7'd0) && !div_valid;

  a_out_valid: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == exp_out_valid)
  else begin
    $display("MISMATCH t=%0t out_valid expected %b actual %b",
             $time, $sampled(exp_out_valid), $sampled(out_valid));
    $display("TEST FAILED");
    $fatal(1, "out_valid check");
  end

  a_result: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && steps_left == 7'd0 && result_known) |-> (result == exp_result))
  else begin
    $display("MISMATCH t=%0t result expected %h actual %h",
             $time, $sampled(exp_result), $sampled(result));
    $display("TEST FAILED");
    $fatal(1, "result check");
  end

  // signed operands get 63-bit magnitudes and divisors are scaled down for wider quotients
  task automatic draw(input logic [1:0] t, input logic fix_signs, input logic a_neg,
                      input logic b_neg, output xlen_t a, output xlen_t b);
    do begin
      rng = xorshift64(rng);
      a   = rng;
      rng = xorshift64(rng);
      b   = rng >> rng[5:0];
      if (fix_signs) begin
        a = {1'b0, a[62:0]};
        b = {1'b0, b[62:0]};
        if (a_neg) a = ~a + 64'd1;
        if (b_neg) b = ~b + 64'd1;
      end
    end while (b == '0 || (t[0] && a == 64'h8000_0000_0000_0000 && b == '1));
  endtask

  task automatic issue(input xlen_t a, input xlen_t b, input logic [1:0] t);
    @(posedge clk);
    #1;
    dividend  = a;
    divisor   = b;
    div_type  = t;
    req_exp   = ref_result(a, b, t);
    div_valid = 1'b1;
    @(posedge clk);
    #1;
    div_valid = 1'b0;
  endtask

  task automatic wait_done();
    while (!out_valid) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_one(input logic [1:0] t, input logic fix_signs, input logic a_neg,
                         input logic b_neg);
    xlen_t a;
    xlen_t b;
    draw(t, fix_signs, a_neg, b_neg, a, b);
    issue(a, b, t);
    wait_done();
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: divisions did not finish within %0d time units", WATCHDOG_TIME);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    xlen_t a;
    xlen_t b;
    clk           = 1'b0;
    rst_n         = 1'b0;
    dividend      = '0;
    divisor       = '0;
    div_valid     = 1'b0;
    div_type      = 2'b00;
    flush         = 1'b0;
    req_exp       = '0;
    rng           = 64'd77;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);

    for (int i = 0; i < 40; i++) run_one(2'b00, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < 40; i++) run_one(2'b10, 1'b0, 1'b0, 1'b0);

    // all four sign pairs for quotient and remainder
    for (int s = 0; s < 4; s++) begin
      for (int k = 0; k < 4; k++) begin
        run_one(2'b01, 1'b1, s[1], s[0]);
        run_one(2'b11, 1'b1, s[1], s[0]);
      end
    end

    // flush mid-division and then a clean request
    draw(2'b00, 1'b0, 1'b0, 1'b0, a, b);
    issue(a, b, 2'b00);
    repeat (20) @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    run_one(2'b11, 1'b1, 1'b1, 1'b0);

    // restart while busy so the second operands win
    draw(2'b01, 1'b1, 1'b0, 1'b1, a, b);
    issue(a, b, 2'b01);
    repeat (30) @(posedge clk);
    draw(2'b10, 1'b0, 1'b0, 1'b0, a, b);
    issue(a, b, 2'b10);
    wait_done();

    repeat (4) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule
